/* include/mem_sdp_consts.svh */
`ifndef MEM_SDP_CONSTS_SVH
`define MEM_SDP_CONSTS_SVH

// word address width.
`define MEM_ADDR_WID 7

// width of one stored word.
`define MEM_DATA_WID 113

// 1 zero-fills the array after reset, 0 skips straight to ready.
`define MEM_CLEAR_EN 1

// number of words held by the array.
`define MEM_DEPTH (1 << `MEM_ADDR_WID)

`endif

/* hdl/mem_sdp_pkg.sv */
`include "mem_sdp_consts.svh"

package mem_sdp_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths with a meaning.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // word address.
    typedef logic [`MEM_ADDR_WID-1:0] addr_t;

    // one stored word.
    typedef logic [`MEM_DATA_WID-1:0] data_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // start-up sequencer.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        CLEAR = 2'd1,
        READY = 2'd2
    } clear_state_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // staged port commands.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // write command, strobe set only for an accepted request.
    typedef struct packed {
        logic  strobe;
        addr_t addr;
        data_t data;
    } wr_req_t;

    // read command.
    typedef struct packed {
        logic  strobe;
        addr_t addr;
    } rd_req_t;

endpackage : mem_sdp_pkg

/* hdl/mem_clear_fsm.sv */
`timescale 1ns/1ps

module mem_clear_fsm
    import mem_sdp_pkg::*;
#(
    parameter bit CLEAR_EN = 1'b1
)(
    input  logic rd_clk,
    input  logic rd_srst,
    input  logic clear_last,
    output logic clear_active,
    output logic mem_ready
);

    clear_state_t state;
    clear_state_t state_nxt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // next state.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                // leave idle on the first edge after reset.
                if (CLEAR_EN) begin
                    state_nxt = CLEAR;
                end else begin
                    state_nxt = READY;
                end
            end
            CLEAR: begin
                if (clear_last) begin
                    state_nxt = READY;
                end
            end
            READY: begin
                state_nxt = READY;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge rd_clk) begin
        if (rd_srst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // outputs.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign clear_active = (state == CLEAR);
    assign mem_ready    = (state == READY);

    // ready is sticky until the next reset.
    a_ready_sticky : assert property (
        @(posedge rd_clk) disable iff (rd_srst)
        (state == READY) |=> (state == READY)
    ) else $error("clear fsm left READY without reset.");

endmodule : mem_clear_fsm

/* hdl/mem_clear_counter.sv */
`timescale 1ns/1ps
`include "mem_sdp_consts.svh"

module mem_clear_counter
    import mem_sdp_pkg::*;
(
    input  logic  rd_clk,
    input  logic  rd_srst,
    input  logic  clear_active,
    output addr_t clear_addr,
    output logic  clear_last
);

    localparam addr_t LAST_ADDR = addr_t'(`MEM_DEPTH - 1);

    addr_t cnt;

    // walks 0 to depth-1 and wraps back to zero after the last word.
    always_ff @(posedge rd_clk) begin
        if (rd_srst) begin
            cnt <= '0;
        end else if (clear_active) begin
            cnt <= cnt + addr_t'(1);
        end
    end

    assign clear_addr = cnt;

    // flagged while the final word is being zeroed.
    assign clear_last = clear_active && (cnt == LAST_ADDR);

    // the sequencer stops on the wrap and the counter rests at zero outside clearing.
    a_cnt_hold : assert property (
        @(posedge rd_clk) disable iff (rd_srst)
        !clear_active |-> (clear_addr == '0)
    ) else $error("clear counter left zero while clear was inactive.");

endmodule : mem_clear_counter

/* hdl/mem_sdp_array.sv */
`timescale 1ns/1ps
`include "mem_sdp_consts.svh"

module mem_sdp_array
    import mem_sdp_pkg::*;
(
    input  logic    rd_clk,
    input  logic    rd_srst,
    input  wr_req_t wr_cmd,
    input  rd_req_t rd_cmd,
    input  logic    clear_active,
    input  addr_t   clear_addr,
    output data_t   rd_word,
    output logic    wr_done,
    output logic    rd_done
);

    data_t mem [`MEM_DEPTH];

    logic  mem_we;
    addr_t mem_waddr;
    data_t mem_wdata;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write port mux.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // zero-fill owns the write port while clearing.
    always_comb begin
        if (clear_active) begin
            mem_we    = 1'b1;
            mem_waddr = clear_addr;
            mem_wdata = '0;
        end else begin
            mem_we    = wr_cmd.strobe;
            mem_waddr = wr_cmd.addr;
            mem_wdata = wr_cmd.data;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge rd_clk) begin
        if (mem_we) begin
            mem[mem_waddr] <= mem_wdata;
        end
    end

    // read-first: a same-edge write to this address lands after the read.
    always_ff @(posedge rd_clk) begin
        if (rd_cmd.strobe) begin
            rd_word <= mem[rd_cmd.addr];
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // completion strobes.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge rd_clk) begin
        if (rd_srst) begin
            wr_done <= 1'b0;
            rd_done <= 1'b0;
        end else begin
            wr_done <= wr_cmd.strobe && !clear_active;
            rd_done <= rd_cmd.strobe;
        end
    end

    // the top holds rdy low until clearing is over.
    a_no_user_wr_in_clear : assert property (
        @(posedge rd_clk) disable iff (rd_srst)
        clear_active |-> !wr_cmd.strobe
    ) else $error("user write reached the array during zero-fill.");

endmodule : mem_sdp_array

/* hdl/mem_sdp_wrapper.sv */
`timescale 1ns/1ps
`include "mem_sdp_consts.svh"

module mem_sdp_wrapper
    import mem_sdp_pkg::*;
(
    input  logic  rd_clk,
    input  logic  rd_srst,

    input  logic  wr_en,
    input  logic  wr_req,
    input  addr_t wr_addr,
    input  data_t wr_data,
    output logic  wr_rdy,
    output logic  wr_ack,

    input  logic  rd_en,
    input  logic  rd_req,
    input  addr_t rd_addr,
    output data_t rd_data,
    output logic  rd_rdy,
    output logic  rd_ack,

    output logic  init_done
);

    wr_req_t wr_cmd;
    rd_req_t rd_cmd;

    logic  clear_active;
    logic  clear_last;
    logic  mem_ready;
    addr_t clear_addr;

    data_t rd_word;
    logic  wr_done;
    logic  rd_done;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // input staging.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // a command counts only with req, en and rdy all high.
    always_ff @(posedge rd_clk) begin
        wr_cmd.addr <= wr_addr;
        wr_cmd.data <= wr_data;
        if (rd_srst) begin
            wr_cmd.strobe <= 1'b0;
        end else begin
            wr_cmd.strobe <= wr_req && wr_en && wr_rdy;
        end
    end

    always_ff @(posedge rd_clk) begin
        rd_cmd.addr <= rd_addr;
        if (rd_srst) begin
            rd_cmd.strobe <= 1'b0;
        end else begin
            rd_cmd.strobe <= rd_req && rd_en && rd_rdy;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output registers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge rd_clk) begin
        if (rd_srst) begin
            wr_rdy    <= 1'b0;
            rd_rdy    <= 1'b0;
            wr_ack    <= 1'b0;
            rd_ack    <= 1'b0;
            init_done <= 1'b0;
        end else begin
            wr_rdy    <= mem_ready;
            rd_rdy    <= mem_ready;
            wr_ack    <= wr_done;
            rd_ack    <= rd_done;
            init_done <= mem_ready;
        end
    end

    // read data holds between acks.
    always_ff @(posedge rd_clk) begin
        if (rd_done) begin
            rd_data <= rd_word;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sequencer, counter and array.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    mem_clear_fsm #(
        .CLEAR_EN     ( 1'(`MEM_CLEAR_EN) )
    ) i_mem_clear_fsm (
        .rd_clk       ( rd_clk       ),
        .rd_srst      ( rd_srst      ),
        .clear_last   ( clear_last   ),
        .clear_active ( clear_active ),
        .mem_ready    ( mem_ready    )
    );

    mem_clear_counter i_mem_clear_counter (
        .rd_clk       ( rd_clk       ),
        .rd_srst      ( rd_srst      ),
        .clear_active ( clear_active ),
        .clear_addr   ( clear_addr   ),
        .clear_last   ( clear_last   )
    );

    mem_sdp_array i_mem_sdp_array (
        .rd_clk       ( rd_clk       ),
        .rd_srst      ( rd_srst      ),
        .wr_cmd       ( wr_cmd       ),
        .rd_cmd       ( rd_cmd       ),
        .clear_active ( clear_active ),
        .clear_addr   ( clear_addr   ),
        .rd_word      ( rd_word      ),
        .wr_done      ( wr_done      ),
        .rd_done      ( rd_done      )
    );

endmodule : mem_sdp_wrapper

/* verification/mem_sdp_model.svh */
`ifndef MEM_SDP_MODEL_SVH
`define MEM_SDP_MODEL_SVH

// one predicted read, known is low for a word never cleared or written.
typedef struct packed {
    logic  known;
    addr_t addr;
    data_t data;
} rd_pred_t;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reference memory.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

data_t    ref_mem   [`MEM_DEPTH];
logic     ref_known [`MEM_DEPTH];
rd_pred_t rd_pred_q [$];

// expected acks, bit 2 is due in the current cycle.
logic [2:0] wr_ack_due;
logic [2:0] rd_ack_due;

task automatic model_reset();
    for (int i = 0; i < `MEM_DEPTH; i++) begin
        ref_mem[i]   = '0;
        ref_known[i] = 1'(`MEM_CLEAR_EN);
    end
    rd_pred_q.delete();
    wr_ack_due = '0;
    rd_ack_due = '0;
endtask

// read-first: the read is predicted before a same-cycle write lands.
task automatic model_accept(input logic w_acc, input addr_t w_addr, input data_t w_data,
                            input logic r_acc, input addr_t r_addr);
    rd_pred_t pred;
    if (r_acc) begin
        pred.known = ref_known[r_addr];
        pred.addr  = r_addr;
        pred.data  = ref_mem[r_addr];
        rd_pred_q.push_back(pred);
    end
    if (w_acc) begin
        ref_mem[w_addr]   = w_data;
        ref_known[w_addr] = 1'b1;
    end
    wr_ack_due[0] = w_acc;
    rd_ack_due[0] = r_acc;
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// compare tasks.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
        $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
        fail_and_stop();
    end
endtask

task automatic check_addr_word(input string name, input addr_t addr,
                               input data_t got, input data_t exp);
    if (got !== exp) begin
        $display("Fail %s at addr 0x%0h: got 0x%0h, expected 0x%0h", name, addr, got, exp);
        fail_and_stop();
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
        fail_and_stop();
    end
endtask

`endif

/* verification/tb_mem_sdp.sv */
`timescale 1ns/1ps
`include "mem_sdp_consts.svh"

module tb_mem_sdp
    import mem_sdp_pkg::*;
();

    localparam int INIT_LIMIT  = `MEM_DEPTH + 8;
    localparam int DRAIN_LIMIT = 8;
    localparam int MIX_CYCLES  = 400;
    localparam int WR_BURST    = 32;

    logic  rd_clk;
    logic  rd_srst;
    logic  wr_en;
    logic  wr_req;
    addr_t wr_addr;
    data_t wr_data;
    logic  wr_rdy;
    logic  wr_ack;
    logic  rd_en;
    logic  rd_req;
    addr_t rd_addr;
    data_t rd_data;
    logic  rd_rdy;
    logic  rd_ack;
    logic  init_done;

    logic  ready_seen;
    logic  have_last_rd;
    data_t last_rd;
    int    n_wr_acked;
    int    n_rd_checked;
    addr_t wr_list [WR_BURST];

    task automatic fail_and_stop();
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopping on the first error.");
    endtask

    `include "mem_sdp_model.svh"

    mem_sdp_wrapper dut0 (
        .rd_clk    ( rd_clk    ),
        .rd_srst   ( rd_srst   ),
        .wr_en     ( wr_en     ),
        .wr_req    ( wr_req    ),
        .wr_addr   ( wr_addr   ),
        .wr_data   ( wr_data   ),
        .wr_rdy    ( wr_rdy    ),
        .wr_ack    ( wr_ack    ),
        .rd_en     ( rd_en     ),
        .rd_req    ( rd_req    ),
        .rd_addr   ( rd_addr   ),
        .rd_data   ( rd_data   ),
        .rd_rdy    ( rd_rdy    ),
        .rd_ack    ( rd_ack    ),
        .init_done ( init_done )
    );

    initial begin
        rd_clk = 1'b0;
        forever begin
            #10 rd_clk = ~rd_clk;
        end
    end

    function automatic addr_t rand_addr();
        return addr_t'($urandom);
    endfunction

    function automatic data_t rand_data();
        logic [127:0] raw;
        raw = {$urandom, $urandom, $urandom, $urandom};
        return raw[`MEM_DATA_WID-1:0];
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // per-cycle checks and drive.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // samples 2 ns after the edge, then leaves the ports idle.
    task automatic observe_cycle();
        rd_pred_t pred;
        @(posedge rd_clk);
        #2;
        if (init_done) begin
            ready_seen = 1'b1;
        end
        check_flag("init_done", init_done, ready_seen);
        check_flag("wr_rdy", wr_rdy, ready_seen);
        check_flag("rd_rdy", rd_rdy, ready_seen);
        check_flag("wr_ack", wr_ack, wr_ack_due[2]);
        check_flag("rd_ack", rd_ack, rd_ack_due[2]);
        if (wr_ack) begin
            n_wr_acked++;
        end
        if (rd_ack) begin
            pred = rd_pred_q.pop_front();
            if (pred.known) begin
                check_addr_word("rd_data", pred.addr, rd_data, pred.data);
            end
            last_rd      = rd_data;
            have_last_rd = 1'b1;
            n_rd_checked++;
        end else if (have_last_rd) begin
            check_data("rd_data", rd_data, last_rd);
        end
        wr_ack_due = {wr_ack_due[1:0], 1'b0};
        rd_ack_due = {rd_ack_due[1:0], 1'b0};
        wr_req = 1'b0;
        wr_en  = 1'b0;
        rd_req = 1'b0;
        rd_en  = 1'b0;
    endtask

    task automatic drive_inputs(input logic w_req, input logic w_en, input addr_t w_addr,
                                input data_t w_data, input logic r_req, input logic r_en,
                                input addr_t r_addr);
        logic w_acc;
        logic r_acc;
        w_acc = w_req && w_en && wr_rdy;
        r_acc = r_req && r_en && rd_rdy;
        model_accept(w_acc, w_addr, w_data, r_acc, r_addr);
        wr_req  = w_req;
        wr_en   = w_en;
        wr_addr = w_addr;
        wr_data = w_data;
        rd_req  = r_req;
        rd_en   = r_en;
        rd_addr = r_addr;
    endtask

    task automatic run_cycle(input logic w_req, input logic w_en, input addr_t w_addr,
                             input data_t w_data, input logic r_req, input logic r_en,
                             input addr_t r_addr);
        observe_cycle();
        drive_inputs(w_req, w_en, w_addr, w_data, r_req, r_en, r_addr);
    endtask

    // requests made while init is running must be dropped.
    task automatic wait_init();
        int cycles;
        cycles = 0;
        forever begin
            observe_cycle();
            if (init_done) begin
                break;
            end
            cycles++;
            if (cycles > INIT_LIMIT) begin
                $display("init_done did not rise within %0d cycles of reset.", INIT_LIMIT);
                fail_and_stop();
            end
            drive_inputs(1'b1, 1'b1, rand_addr(), rand_data(), 1'b1, 1'b1, rand_addr());
        end
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        forever begin
            observe_cycle();
            if (rd_pred_q.size() == 0 && wr_ack_due == '0 && rd_ack_due == '0) begin
                break;
            end
            cycles++;
            if (cycles > DRAIN_LIMIT) begin
                $display("outstanding acks never arrived within %0d cycles.", DRAIN_LIMIT);
                fail_and_stop();
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        logic [1:0] op;
        logic       w_en_v;
        logic       r_en_v;
        addr_t      wa;
        addr_t      ra;
        int         gap;
        void'($urandom(32'hacd936bf));
        rd_srst      = 1'b1;
        wr_en        = 1'b0;
        wr_req       = 1'b0;
        wr_addr      = '0;
        wr_data      = '0;
        rd_en        = 1'b0;
        rd_req       = 1'b0;
        rd_addr      = '0;
        ready_seen   = 1'b0;
        have_last_rd = 1'b0;
        last_rd      = '0;
        n_wr_acked   = 0;
        n_rd_checked = 0;
        model_reset();

        repeat (16) @(posedge rd_clk);
        #2;
        check_flag("wr_rdy", wr_rdy, 1'b0);
        check_flag("rd_rdy", rd_rdy, 1'b0);
        check_flag("wr_ack", wr_ack, 1'b0);
        check_flag("rd_ack", rd_ack, 1'b0);
        check_flag("init_done", init_done, 1'b0);
        rd_srst = 1'b0;
        wait_init();

        // every word reads back as zero after the fill.
        if (`MEM_CLEAR_EN) begin
            for (int a = 0; a < `MEM_DEPTH; a++) begin
                run_cycle(1'b0, 1'b0, '0, '0, 1'b1, 1'b1, addr_t'(a));
            end
            wait_idle();
        end

        for (int i = 0; i < WR_BURST; i++) begin
            wr_list[i] = rand_addr();
            run_cycle(1'b1, 1'b1, wr_list[i], rand_data(), 1'b0, 1'b0, '0);
        end
        gap = int'($urandom % 4);
        repeat (gap) run_cycle(1'b0, 1'b0, '0, '0, 1'b0, 1'b0, '0);
        for (int i = 0; i < WR_BURST; i++) begin
            run_cycle(1'b0, 1'b0, '0, '0, 1'b1, 1'b1, wr_list[i]);
        end
        wait_idle();

        // en low: no ack and no change to memory.
        for (int i = 0; i < 16; i++) begin
            run_cycle(1'b1, 1'b0, addr_t'(i), rand_data(), 1'b1, 1'b0, addr_t'(i));
        end
        for (int i = 0; i < 16; i++) begin
            run_cycle(1'b0, 1'b0, '0, '0, 1'b1, 1'b1, addr_t'(i));
        end
        wait_idle();

        // narrow address range half the time, so hits are frequent.
        for (int c = 0; c < MIX_CYCLES; c++) begin
            op     = 2'($urandom);
            w_en_v = ($urandom % 8) != 0;
            r_en_v = ($urandom % 8) != 0;
            wa     = (($urandom % 2) != 0) ? addr_t'($urandom % 8) : rand_addr();
            ra     = (($urandom % 2) != 0) ? addr_t'($urandom % 8) : rand_addr();
            if (op == 2'b11 && ($urandom % 2) != 0) begin
                ra = wa;
            end
            run_cycle(op[0], w_en_v, wa, rand_data(), op[1], r_en_v, ra);
        end
        wait_idle();

        $display("%0d writes and %0d reads acknowledged.", n_wr_acked, n_rd_checked);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule : tb_mem_sdp

/* mem_sdp_wrapper.f */
+incdir+include
+incdir+verification
hdl/mem_sdp_pkg.sv
hdl/mem_clear_fsm.sv
hdl/mem_clear_counter.sv
hdl/mem_sdp_array.sv
hdl/mem_sdp_wrapper.sv
verification/tb_mem_sdp.sv

/* Makefile */
# Verilator build and run for the simple dual-port RAM subsystem.

VERILATOR  ?= verilator
VFLAGS     = --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS = --lint-only --timing --assert --timescale 1ns/1ps -Wall
TOP        = tb_mem_sdp
RTL_TOP    = mem_sdp_wrapper
FILELIST   = mem_sdp_wrapper.f
BUILD_DIR  = obj_dir
LOG        = sim.log
FAIL_MSG   = TEST RESULT: FAIL
PASS_MSG   = TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a verdict, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
